// ==== logic/nmea_pkg.sv ====
// shared bus, receiver and record types; paddr is 5 bits so only offsets below 0x20 decode
package nmea_pkg;

  localparam int stamp_width = 24;  // width of the free running xclk stamp

  // apb request from the host side
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;     // byte offset, see reg_addr_e
    logic [31:0] pwdata;
  } apb_req_t;

  // apb response, no wait states and no slave errors
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // bit level events from the serial receiver
  typedef struct packed {
    logic bit_val;    // last sampled data bit
    logic bit_stb;    // one cycle per data bit
    logic start;      // start edge seen
    logic ts_stb;     // first start after a full idle slot
    logic frame_err;  // stop bit read low
    logic pause;      // line idle for a whole character slot
  } rcv_bits_t;

  // character fifo record
  typedef struct packed {
    logic       sof;   // first char of a sentence
    logic [7:0] data;
  } char_rec_t;

  // timestamp fifo record
  typedef struct packed {
    logic [stamp_width-1:0] stamp;  // xclk count at the sentence start
  } ts_rec_t;

  typedef enum logic [4:0] {
    ctrl_addr   = 5'h00,  // enable, resync
    half_addr   = 5'h04,  // half bit period in xclk cycles
    status_addr = 5'h08,  // fifo flags and frame error count
    char_addr   = 5'h0C,  // pops one char record
    ts_addr     = 5'h10   // pops one timestamp record
  } reg_addr_e;

endpackage

// ==== logic/serial_bit_rcv.sv ====
// 8N1 lsb first only; half_period must be at least 2 and is read live, so change it under resync
`timescale 1ns/1ps

module serial_bit_rcv import nmea_pkg::*; (
  input  logic        xclk,
  input  logic        reset_bit_duration,
  input  logic        ser_rst,       // holds the receiver resynced
  input  logic [15:0] half_period,   // half bit time in xclk cycles
  input  logic        ser_di,        // raw ttl serial line
  output rcv_bits_t   rcv_bits
);

  logic        resync;              // system reset or software resync
  logic [4:0]  di_hist;             // last five raw samples
  logic        filt_di;             // filtered line
  logic        filt_di_d;           // filtered line, one cycle late
  logic [15:0] half_cnt;            // half bit down counter
  logic        half_end;            // last cycle of a half bit
  logic [4:0]  half_idx;            // half slots left in the character
  logic        last_half;           // in the final half slot
  logic        slot_end;
  logic        wait_pause;          // idle slot still running
  logic        wait_start;          // armed for a start edge
  logic        receiving;
  logic        shift_en;            // inside the data bit window
  logic [1:0]  restart;             // delays the pause restart after a frame
  logic        restart_pause;
  logic        start_edge;
  logic        sample_bit;
  logic        stop_low;
  logic        half_period_reload;

  assign resync             = reset_bit_duration || ser_rst;
  assign slot_end           = last_half && half_end;
  assign start_edge         = wait_start && filt_di_d && !filt_di;  // falling edge only when armed
  assign restart_pause      = (restart[1] && !restart[0]) ||
                              (wait_pause && !wait_start && !filt_di);  // low line restarts idle
  assign sample_bit         = shift_en && half_end && !half_idx[0];  // middle of each data bit
  assign stop_low           = receiving && slot_end && !filt_di;
  assign half_period_reload = restart_pause || rcv_bits.start || half_end;

  // a level is accepted only when all five samples agree
  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      di_hist   <= '1;                 // idle line is high
      filt_di   <= 1'b1;
      filt_di_d <= 1'b1;
    end else begin
      di_hist <= {di_hist[3:0], ser_di};
      if (ser_rst || &di_hist) filt_di <= 1'b1;
      else if (~|di_hist)      filt_di <= 1'b0;
      filt_di_d <= filt_di;
    end
  end

  always_ff @(posedge xclk) begin
    if (resync) begin
      half_cnt   <= half_period;
      half_end   <= 1'b0;
      half_idx   <= 5'h13;             // 20 half slots make one idle character
      last_half  <= 1'b0;
      wait_pause <= 1'b0;
      wait_start <= 1'b0;
      receiving  <= 1'b0;
      shift_en   <= 1'b0;
      restart    <= 2'b11;             // release of resync starts the first pause
    end else begin
      if (half_period_reload) half_cnt <= half_period;
      else                    half_cnt <= half_cnt - 16'd1;
      half_end <= (half_cnt == 16'd2) && !half_period_reload;  // high while the count is 1

      if (restart_pause)       half_idx <= 5'h13;
      else if (rcv_bits.start) half_idx <= 5'h12;  // start bit takes two halves
      else if (half_end)       half_idx <= half_idx - 5'd1;
      last_half <= (half_idx == 5'd0) && !half_end;

      restart    <= {restart[0], receiving && slot_end};
      wait_pause <= restart_pause || (receiving && slot_end) ||
                    (wait_pause && !slot_end && !(wait_start && !filt_di));
      wait_start <= ((wait_pause || receiving) && slot_end) || (wait_start && !start_edge);
      receiving  <= rcv_bits.start || (receiving && !slot_end);  // ends mid stop bit

      // window opens in the start bit and closes after bit 7
      if (half_end && (half_idx[3:0] == 4'h2)) shift_en <= receiving && half_idx[4];
      else                                      shift_en <= receiving && shift_en;
    end
  end

  always_ff @(posedge xclk) begin
    if (resync) begin
      rcv_bits <= '0;
    end else begin
      rcv_bits.start     <= start_edge;
      rcv_bits.ts_stb    <= start_edge && !wait_pause;  // back to back chars give no stamp
      if (sample_bit) rcv_bits.bit_val <= filt_di;
      rcv_bits.bit_stb   <= sample_bit;
      rcv_bits.frame_err <= stop_low;
      rcv_bits.pause     <= wait_start && !wait_pause;
    end
  end

endmodule

// ==== logic/char_assembler.sv ====
// expects exactly eight bit strobes per start; a partial byte is dropped at the next start or idle
`timescale 1ns/1ps

module char_assembler import nmea_pkg::*; (
  input  logic      xclk,
  input  logic      reset_bit_duration,
  input  rcv_bits_t rcv_bits,
  output logic      push,   // one cycle per complete character
  output char_rec_t rec
);

  logic [6:0] shreg;     // first seven bits, lsb arrives first
  logic [2:0] bit_cnt;   // data bits taken so far
  logic       sof_pend;  // sentence start seen, first char not pushed yet

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      bit_cnt  <= '0;
      sof_pend <= 1'b0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      if (rcv_bits.start || rcv_bits.pause) begin
        bit_cnt <= '0;                             // realign on every frame
      end else if (rcv_bits.bit_stb) begin
        bit_cnt <= bit_cnt + 3'd1;                 // wraps to 0 after bit 7
        push    <= (bit_cnt == 3'd7);
      end
      if (rcv_bits.ts_stb)                                   sof_pend <= 1'b1;
      else if (rcv_bits.bit_stb && (bit_cnt == 3'd7))        sof_pend <= 1'b0;
    end
  end

  // record data, loaded with the eighth bit
  always_ff @(posedge xclk) begin
    if (rcv_bits.bit_stb) shreg <= {rcv_bits.bit_val, shreg[6:1]};
    if (rcv_bits.bit_stb && (bit_cnt == 3'd7)) begin
      rec.data <= {rcv_bits.bit_val, shreg};       // msb is the last bit on the line
      rec.sof  <= sof_pend;
    end
  end

endmodule

// ==== logic/sync_fifo.sv ====
// fifo_depth must be a power of two, at least 2; pushes into a full fifo are lost
`timescale 1ns/1ps

module sync_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  fifo_depth = 16
) (
  input  logic     xclk,
  input  logic     reset_bit_duration,
  input  logic     push,
  input  payload_t wdata,
  input  logic     pop,
  output payload_t rdata,     // head entry, valid while nonempty
  output logic     nonempty,
  output logic     overflow   // sticky until reset
);

  localparam int aw = $clog2(fifo_depth);

  payload_t    mem [fifo_depth];
  logic [aw:0] wr_ptr;        // extra msb tells full from empty
  logic [aw:0] rd_ptr;
  logic        full;
  logic        wr_en;
  logic        rd_en;

  assign full     = (wr_ptr[aw] != rd_ptr[aw]) && (wr_ptr[aw-1:0] == rd_ptr[aw-1:0]);
  assign nonempty = (wr_ptr != rd_ptr);
  assign wr_en    = push && !full;
  assign rd_en    = pop && nonempty;   // pop on empty is ignored
  assign rdata    = mem[rd_ptr[aw-1:0]];

  always_ff @(posedge xclk) begin
    if (wr_en) mem[wr_ptr[aw-1:0]] <= wdata;
  end

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      overflow <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      if (push && full) overflow <= 1'b1;  // dropped record
    end
  end

endmodule

// ==== logic/nmea_apb_ctrl.sv ====
// apb without wait states; read data is only valid in the access phase and a read pops at once
`timescale 1ns/1ps

module nmea_apb_ctrl import nmea_pkg::*; #(
  parameter logic [15:0] default_half_period = 16'd8
) (
  input  logic        xclk,
  input  logic        reset_bit_duration,
  input  apb_req_t    apb_req,
  output apb_rsp_t    apb_rsp,
  output logic        ser_rst,        // receiver resync
  output logic [15:0] half_period,
  input  rcv_bits_t   rcv_bits,
  output logic        ts_push,
  output ts_rec_t     ts_rec,
  input  char_rec_t   char_head,
  input  logic        char_nonempty,
  input  logic        char_overflow,
  output logic        char_pop,
  input  ts_rec_t     ts_head,
  input  logic        ts_nonempty,
  output logic        ts_pop
);

  logic                   enable;
  logic                   resync_q;         // one cycle after a resync write
  logic [stamp_width-1:0] ts_cnt;           // free running xclk count
  logic [7:0]             frame_err_count;  // saturates at 255
  logic                   wr_xfer;
  logic                   rd_xfer;
  reg_addr_e              addr;

  assign addr     = reg_addr_e'(apb_req.paddr);
  assign wr_xfer  = apb_req.psel && apb_req.penable && apb_req.pwrite;
  assign rd_xfer  = apb_req.psel && apb_req.penable && !apb_req.pwrite;
  assign ser_rst  = !enable || resync_q;   // held while disabled
  assign char_pop = rd_xfer && (addr == char_addr) && char_nonempty;
  assign ts_pop   = rd_xfer && (addr == ts_addr) && ts_nonempty;

  // stamp goes in with the strobe itself
  assign ts_push      = rcv_bits.ts_stb;
  assign ts_rec.stamp = ts_cnt;

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      enable          <= 1'b0;
      resync_q        <= 1'b0;
      half_period     <= default_half_period;
      ts_cnt          <= '0;
      frame_err_count <= '0;
    end else begin
      ts_cnt   <= ts_cnt + 1'b1;
      resync_q <= wr_xfer && (addr == ctrl_addr) && apb_req.pwdata[1];  // write only bit
      if (wr_xfer && (addr == ctrl_addr)) enable      <= apb_req.pwdata[0];
      if (wr_xfer && (addr == half_addr)) half_period <= apb_req.pwdata[15:0];
      if (rcv_bits.frame_err && (frame_err_count != 8'hff)) begin
        frame_err_count <= frame_err_count + 8'd1;
      end
    end
  end

  // read mux, bit 31 flags a popped record
  always_comb begin
    apb_rsp         = '0;
    apb_rsp.pready  = 1'b1;
    apb_rsp.pslverr = 1'b0;
    if (rd_xfer) begin
      case (addr)
        ctrl_addr:   apb_rsp.prdata = {31'b0, enable};   // resync reads as 0
        half_addr:   apb_rsp.prdata = {16'b0, half_period};
        status_addr: apb_rsp.prdata = {16'b0, frame_err_count, 5'b0,
                                       char_overflow, ts_nonempty, char_nonempty};
        char_addr: begin
          if (char_nonempty) apb_rsp.prdata = {1'b1, 22'b0, char_head};
        end
        ts_addr: begin
          if (ts_nonempty) apb_rsp.prdata = {1'b1, 7'b0, ts_head};
        end
        default:     apb_rsp.prdata = '0;              // unmapped offsets read 0
      endcase
    end
  end

endmodule

// ==== logic/nmea_top.sv ====
// single xclk domain; ser_di must be synchronous to xclk or already resynchronized
`timescale 1ns/1ps

module nmea_top import nmea_pkg::*; #(
  parameter logic [15:0] default_half_period = 16'd8,
  parameter int          fifo_depth          = 16    // power of two
) (
  input  logic     xclk,
  input  logic     reset_bit_duration,
  input  logic     ser_di,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  logic        ser_rst;
  logic [15:0] half_period;
  rcv_bits_t   rcv_bits;
  logic        char_push;
  char_rec_t   char_rec;
  logic        char_pop;
  char_rec_t   char_head;
  logic        char_nonempty;
  logic        char_overflow;
  logic        ts_push;
  ts_rec_t     ts_rec;
  logic        ts_pop;
  ts_rec_t     ts_head;
  logic        ts_nonempty;

  serial_bit_rcv rcv0 (
    .xclk, .reset_bit_duration, .ser_rst, .half_period, .ser_di, .rcv_bits
  );

  char_assembler asm0 (
    .xclk, .reset_bit_duration, .rcv_bits, .push (char_push), .rec (char_rec)
  );

  sync_fifo #(.payload_t (char_rec_t), .fifo_depth (fifo_depth)) char_fifo (
    .xclk, .reset_bit_duration, .push (char_push), .wdata (char_rec), .pop (char_pop),
    .rdata (char_head), .nonempty (char_nonempty), .overflow (char_overflow)
  );

  sync_fifo #(.payload_t (ts_rec_t), .fifo_depth (fifo_depth)) ts_fifo (
    .xclk, .reset_bit_duration, .push (ts_push), .wdata (ts_rec), .pop (ts_pop),
    .rdata (ts_head), .nonempty (ts_nonempty), .overflow ()  // ts loss not reported
  );

  nmea_apb_ctrl #(.default_half_period (default_half_period)) ctrl0 (
    .xclk, .reset_bit_duration, .apb_req, .apb_rsp, .ser_rst, .half_period, .rcv_bits,
    .ts_push, .ts_rec, .char_head, .char_nonempty, .char_overflow, .char_pop,
    .ts_head, .ts_nonempty, .ts_pop
  );

endmodule

// ==== sim/nmea_chk.sv ====
// protocol rules only, data values are checked by the testbench; bound into every nmea_top
`timescale 1ns/1ps

module nmea_chk import nmea_pkg::*; (
  input logic      xclk,
  input logic      reset_bit_duration,
  input apb_req_t  apb_req,
  input apb_rsp_t  apb_rsp,
  input logic      ser_rst,
  input rcv_bits_t rcv_bits,
  input logic      char_pop,
  input logic      char_nonempty,
  input logic      ts_pop,
  input logic      ts_nonempty
);

  logic       en_written;  // enable has been set by software
  logic [7:0] stb_gap;     // cycles since the last bit strobe, saturating

  always_ff @(posedge xclk) begin
    if (reset_bit_duration) begin
      en_written <= 1'b0;
      stb_gap    <= 8'hff;
    end else begin
      if (apb_req.psel && apb_req.penable && apb_req.pwrite &&
          (apb_req.paddr == ctrl_addr) && apb_req.pwdata[0]) en_written <= 1'b1;
      if (rcv_bits.bit_stb)      stb_gap <= 8'd1;
      else if (stb_gap != 8'hff) stb_gap <= stb_gap + 8'd1;
    end
  end

  pready_high: assert property (@(posedge xclk) apb_rsp.pready)
    else $error("apb pready went low");

  pslverr_low: assert property (@(posedge xclk) !apb_rsp.pslverr)
    else $error("apb pslverr went high");

  rst_until_enable: assert property (@(posedge xclk) disable iff (reset_bit_duration)
    !en_written |-> ser_rst) else $error("receiver released before enable was written");

  char_pop_ok: assert property (@(posedge xclk) disable iff (reset_bit_duration)
    char_pop |-> char_nonempty) else $error("char fifo popped while empty");

  ts_pop_ok: assert property (@(posedge xclk) disable iff (reset_bit_duration)
    ts_pop |-> ts_nonempty) else $error("ts fifo popped while empty");

  bit_spacing: assert property (@(posedge xclk) disable iff (reset_bit_duration)
    rcv_bits.bit_stb |-> (stb_gap > 8'd8)) else $error("bit strobes closer than 8 cycles");

endmodule

bind nmea_top nmea_chk chk0 (
  .xclk, .reset_bit_duration, .apb_req, .apb_rsp, .ser_rst, .rcv_bits,
  .char_pop, .char_nonempty, .ts_pop, .ts_nonempty
);

// ==== sim/nmea_tb.sv ====
// line driver assumes 16 cycles per bit, so half must be 8 while sending; stops at first error
`timescale 1ns/1ps

module nmea_tb import nmea_pkg::*; ();

  localparam int fifo_depth  = 16;
  localparam int bit_cycles  = 16;   // half period 8
  localparam int gap_bits    = 14;   // idle gap, longer than a character slot
  localparam int n_chars     = 6 + 9 + 1 + (fifo_depth + 2) + 1 + 4;
  localparam int n_gaps      = 9;
  localparam int cycle_limit = 3 * (n_chars * 10 + n_gaps * gap_bits) * bit_cycles + 2000;

  logic        xclk;
  logic        reset_bit_duration;
  logic        ser_di;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  integer      seed;
  int          cycle_cnt = 0;
  logic [7:0]  exp_data[$];   // chars expected in the char fifo, oldest first
  logic        exp_sof[$];
  logic [31:0] rd_word;
  logic [23:0] last_stamp;
  logic [7:0]  err_before;    // frame error count before the bad stop bit

  nmea_top #(.default_half_period (16'd8), .fifo_depth (fifo_depth)) dut0 (
    .xclk, .reset_bit_duration, .ser_di, .apb_req, .apb_rsp
  );

  initial begin
    xclk = 1'b0;
    forever #5 xclk = ~xclk;
  end

  always @(posedge xclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("run passed the limit of %0d cycles, a wait on the dut never ended", cycle_limit);
      $display("Simulation failed");
      $fatal(1);
    end
  end

  task automatic report_failure(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
    @(negedge xclk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
    @(negedge xclk);
    apb_req.penable = 1'b1;              // takes effect at the next rising edge
    @(negedge xclk);
    apb_req = '0;
  endtask

  task automatic apb_read(input logic [4:0] addr, output logic [31:0] data);
    @(negedge xclk);
    apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: 32'h0};
    @(negedge xclk);
    apb_req.penable = 1'b1;
    #1 data = apb_rsp.prdata;            // settled access phase data
    @(negedge xclk);
    apb_req = '0;
  endtask

  task automatic send_byte(input logic [7:0] data, input logic stop_bit);
    @(negedge xclk);
    ser_di = 1'b0;                       // start bit
    repeat (bit_cycles) @(negedge xclk);
    for (int i = 0; i < 8; i++) begin
      ser_di = data[i];                  // lsb first
      repeat (bit_cycles) @(negedge xclk);
    end
    ser_di = stop_bit;
    repeat (bit_cycles) @(negedge xclk);
    ser_di = 1'b1;
  endtask

  task automatic idle_bits(input int n);
    ser_di = 1'b1;
    repeat (n * bit_cycles) @(negedge xclk);
  endtask

  // '$' then random payload, back to back
  task automatic send_sentence(input int n);
    logic [7:0] b;
    for (int i = 0; i < n; i++) begin
      b = (i == 0) ? 8'h24 : 8'($random(seed));
      exp_data.push_back(b);
      exp_sof.push_back(i == 0);
      send_byte(b, 1'b1);
    end
  endtask

  task automatic wait_status(input int idx);
    logic [31:0] word;
    word = '0;
    while (!word[idx]) apb_read(status_addr, word);
  endtask

  task automatic drain_fifo(input logic [4:0] addr);
    logic [31:0] word;
    word = 32'h8000_0000;
    while (word[31]) apb_read(addr, word);  // stops at the first empty read
  endtask

  task automatic check_chars(input int n);
    logic [31:0] word;
    for (int i = 0; i < n; i++) begin
      wait_status(0);
      apb_read(char_addr, word);
      assert (word[31] && (word[7:0] == exp_data[0]) && (word[8] == exp_sof[0]))
        else report_failure($sformatf("char %0d read %h, expected data %h sof %b",
                                      i, word, exp_data[0], exp_sof[0]));
      exp_data.delete(0);
      exp_sof.delete(0);
    end
  endtask

  initial begin
    seed               = 32'h1211;
    reset_bit_duration = 1'b1;
    ser_di             = 1'b1;
    apb_req            = '0;
    repeat (5) @(negedge xclk);
    reset_bit_duration = 1'b0;

    // register access after reset
    apb_read(half_addr, rd_word);
    assert (rd_word == 32'd8) else report_failure($sformatf("half reset %h", rd_word));
    apb_read(status_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("status reset %h", rd_word));
    apb_write(half_addr, 32'h0000_1234);
    apb_read(half_addr, rd_word);
    assert (rd_word == 32'h1234) else report_failure($sformatf("half readback %h", rd_word));
    apb_write(half_addr, 32'd8);         // receiver still held, safe to change
    apb_read(char_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("empty char read %h", rd_word));
    apb_read(ts_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("empty ts read %h", rd_word));
    apb_write(ctrl_addr, 32'h1);
    apb_read(ctrl_addr, rd_word);
    assert (rd_word == 32'd1) else report_failure($sformatf("ctrl readback %h", rd_word));
    idle_bits(gap_bits);                 // first pause after release

    // one sentence of six chars
    send_sentence(6);
    idle_bits(gap_bits);
    check_chars(6);
    drain_fifo(ts_addr);

    // three sentences, one stamp each
    repeat (3) begin
      send_sentence(3);
      idle_bits(gap_bits);
    end
    for (int i = 0; i < 3; i++) begin
      wait_status(1);
      apb_read(ts_addr, rd_word);
      assert (rd_word[31] && ((i == 0) || (rd_word[23:0] > last_stamp)))
        else report_failure($sformatf("ts %0d read %h after stamp %h", i, rd_word, last_stamp));
      last_stamp = rd_word[23:0];
    end
    apb_read(ts_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("extra ts record %h", rd_word));
    check_chars(9);

    // low stop bit
    apb_read(status_addr, rd_word);
    err_before = rd_word[15:8];
    send_byte(8'($random(seed)), 1'b0);
    idle_bits(gap_bits);
    rd_word[15:8] = err_before;
    while (rd_word[15:8] == err_before) apb_read(status_addr, rd_word);
    assert (rd_word[15:8] == err_before + 8'd1)
      else report_failure($sformatf("frame_err_count %0d, was %0d", rd_word[15:8], err_before));
    drain_fifo(char_addr);
    drain_fifo(ts_addr);

    // overfill the char fifo, two records get lost
    send_sentence(fifo_depth + 2);
    idle_bits(gap_bits);
    apb_read(status_addr, rd_word);
    assert (rd_word[2]) else report_failure($sformatf("no char_overflow, status %h", rd_word));
    check_chars(fifo_depth);
    exp_data.delete();
    exp_sof.delete();
    apb_read(char_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("char after overflow %h", rd_word));
    drain_fifo(ts_addr);

    // resync in the middle of a byte
    fork
      send_byte(8'($random(seed)), 1'b1);
      begin
        repeat (4 * bit_cycles) @(negedge xclk);
        apb_write(ctrl_addr, 32'h3);     // enable stays set
      end
    join
    idle_bits(gap_bits);
    send_sentence(4);
    idle_bits(gap_bits);
    check_chars(4);
    apb_read(char_addr, rd_word);
    assert (rd_word == 32'd0) else report_failure($sformatf("aborted byte left %h", rd_word));

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== src.f ====
logic/nmea_pkg.sv
logic/serial_bit_rcv.sv
logic/char_assembler.sv
logic/sync_fifo.sv
logic/nmea_apb_ctrl.sv
logic/nmea_top.sv
sim/nmea_chk.sv
sim/nmea_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the nmea receiver testbench with verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module nmea_tb -f src.f -o nmea_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/nmea_sim)
sim_status=$?
printf '%s\n' "$out"

if [ $sim_status -ne 0 ]; then
  echo "simulator returned status $sim_status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
else
  echo "pass message not found in simulator output"
  exit 1
fi
